// File: Makefile
VERILATOR = verilator
FLAGS = --binary --timing --assert -Wno-fatal
TOP = tb_physics_core
FILELIST = list.f

.PHONY: sim clean

sim:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST)
	out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "^Verification passed$$"

clean:
	rm -rf obj_dir

// File: design/axi_lite_regs.sv
`timescale 1ns/1ps

module axi_lite_regs #(
	parameter int ADDR_WIDTH = 8
) (
	input logic S_AXI_ACLK,
	input logic S_AXI_ARESETN,
	input logic [ADDR_WIDTH-1:0] S_AXI_AWADDR,
	input logic S_AXI_AWVALID,
	output logic S_AXI_AWREADY,
	input logic [31:0] S_AXI_WDATA,
	input logic S_AXI_WVALID,
	output logic S_AXI_WREADY,
	output logic [1:0] S_AXI_BRESP,
	output logic S_AXI_BVALID,
	input logic S_AXI_BREADY,
	input logic [ADDR_WIDTH-1:0] S_AXI_ARADDR,
	input logic S_AXI_ARVALID,
	output logic S_AXI_ARREADY,
	output logic [31:0] S_AXI_RDATA,
	output logic [1:0] S_AXI_RRESP,
	output logic S_AXI_RVALID,
	input logic S_AXI_RREADY,
	output logic run,
	output physics_pkg::ball_t start_state,
	output logic load_valid,
	input logic load_ready,
	input physics_pkg::paddle_t paddle1,
	input physics_pkg::paddle_t paddle2,
	input physics_pkg::ball_t ball,
	input physics_pkg::status_t status
);
	import physics_pkg::*;

	logic wr_ready;
	logic wr_en;
	logic rd_en;
	logic [ADDR_WIDTH-1:0] wr_addr;
	logic [ADDR_WIDTH-1:0] rd_addr;
	logic [31:0] rd_word;

	// AW and W are accepted together
	assign S_AXI_AWREADY = wr_ready;
	assign S_AXI_WREADY = wr_ready;
	assign S_AXI_BRESP = 2'b00;
	assign S_AXI_RRESP = 2'b00;

	assign wr_en = wr_ready && S_AXI_AWVALID && S_AXI_WVALID;
	assign rd_en = S_AXI_ARREADY && S_AXI_ARVALID;
	assign wr_addr = {S_AXI_AWADDR[ADDR_WIDTH-1:2], 2'b00};
	assign rd_addr = {S_AXI_ARADDR[ADDR_WIDTH-1:2], 2'b00};

	// ******************************
	// Write channel
	always_ff @(posedge S_AXI_ACLK) begin
		if (!S_AXI_ARESETN) begin
			wr_ready <= 1'b0;
			S_AXI_BVALID <= 1'b0;
		end else begin
			wr_ready <= S_AXI_AWVALID && S_AXI_WVALID && !wr_ready && !S_AXI_BVALID;
			if (wr_en) begin
				S_AXI_BVALID <= 1'b1;
			end else if (S_AXI_BREADY) begin
				S_AXI_BVALID <= 1'b0;
			end
		end
	end

	// Control and start state registers
	always_ff @(posedge S_AXI_ACLK) begin
		if (!S_AXI_ARESETN) begin
			run <= 1'b1;
			load_valid <= 1'b0;
			start_state <= '0;
		end else begin
			// Engine took the load request
			if (load_valid && load_ready) begin
				load_valid <= 1'b0;
			end
			if (wr_en) begin
				case (wr_addr)
					REG_RUN: run <= S_AXI_WDATA[0];
					REG_LOAD: begin
						if (S_AXI_WDATA[0]) begin
							load_valid <= 1'b1;
						end
					end
					REG_START_POS: start_state.pos.x <= S_AXI_WDATA[23:0];
					REG_START_POS + 8'h04: start_state.pos.y <= S_AXI_WDATA[23:0];
					REG_START_POS + 8'h08: start_state.pos.z <= S_AXI_WDATA[23:0];
					REG_START_VEL: start_state.vel.x <= S_AXI_WDATA[23:0];
					REG_START_VEL + 8'h04: start_state.vel.y <= S_AXI_WDATA[23:0];
					REG_START_VEL + 8'h08: start_state.vel.z <= S_AXI_WDATA[23:0];
					default: ;
				endcase
			end
		end
	end

	// ******************************
	// Read channel
	always_ff @(posedge S_AXI_ACLK) begin
		if (!S_AXI_ARESETN) begin
			S_AXI_ARREADY <= 1'b0;
			S_AXI_RVALID <= 1'b0;
		end else begin
			S_AXI_ARREADY <= S_AXI_ARVALID && !S_AXI_ARREADY && !S_AXI_RVALID;
			if (rd_en) begin
				S_AXI_RVALID <= 1'b1;
			end else if (S_AXI_RREADY) begin
				S_AXI_RVALID <= 1'b0;
			end
		end
	end

	always_ff @(posedge S_AXI_ACLK) begin
		if (rd_en) begin
			S_AXI_RDATA <= rd_word;
		end
	end

	// Coordinates read back zero extended
	function automatic logic [31:0] zx(coord_t c);
		return {8'b0, c};
	endfunction

	always_comb begin
		rd_word = '0;
		case (rd_addr)
			REG_RUN: rd_word = {31'b0, run};
			REG_LOAD: rd_word = {31'b0, load_valid};
			REG_START_POS: rd_word = zx(start_state.pos.x);
			REG_START_POS + 8'h04: rd_word = zx(start_state.pos.y);
			REG_START_POS + 8'h08: rd_word = zx(start_state.pos.z);
			REG_START_VEL: rd_word = zx(start_state.vel.x);
			REG_START_VEL + 8'h04: rd_word = zx(start_state.vel.y);
			REG_START_VEL + 8'h08: rd_word = zx(start_state.vel.z);
			REG_P1_POS: rd_word = zx(paddle1.pos.x);
			REG_P1_POS + 8'h04: rd_word = zx(paddle1.pos.y);
			REG_P1_POS + 8'h08: rd_word = zx(paddle1.pos.z);
			REG_P2_POS: rd_word = zx(paddle2.pos.x);
			REG_P2_POS + 8'h04: rd_word = zx(paddle2.pos.y);
			REG_P2_POS + 8'h08: rd_word = zx(paddle2.pos.z);
			REG_P1_VEL: rd_word = zx(paddle1.vel.x);
			REG_P1_VEL + 8'h04: rd_word = zx(paddle1.vel.y);
			REG_P1_VEL + 8'h08: rd_word = zx(paddle1.vel.z);
			REG_P2_VEL: rd_word = zx(paddle2.vel.x);
			REG_P2_VEL + 8'h04: rd_word = zx(paddle2.vel.y);
			REG_P2_VEL + 8'h08: rd_word = zx(paddle2.vel.z);
			REG_BALL_POS: rd_word = zx(ball.pos.x);
			REG_BALL_POS + 8'h04: rd_word = zx(ball.pos.y);
			REG_BALL_POS + 8'h08: rd_word = zx(ball.pos.z);
			REG_BALL_VEL: rd_word = zx(ball.vel.x);
			REG_BALL_VEL + 8'h04: rd_word = zx(ball.vel.y);
			REG_BALL_VEL + 8'h08: rd_word = zx(ball.vel.z);
			REG_IMPACT: rd_word = {31'b0, status.impact_side};
			REG_IN_BOUNDS: rd_word = {31'b0, status.in_bounds};
			REG_LAST_HIT: rd_word = {29'b0, status.last_hit};
			REG_STEPS: rd_word = {16'b0, status.step_count};
			default: rd_word = '0;
		endcase
	end

	// ******************************
	// Handshake checks
	bvalid_hold: assert property (@(posedge S_AXI_ACLK) disable iff (!S_AXI_ARESETN)
		S_AXI_BVALID && !S_AXI_BREADY |=> S_AXI_BVALID);

	rvalid_hold: assert property (@(posedge S_AXI_ACLK) disable iff (!S_AXI_ARESETN)
		S_AXI_RVALID && !S_AXI_RREADY |=> S_AXI_RVALID && $stable(S_AXI_RDATA));

	// Load request waits for the engine
	load_hold: assert property (@(posedge S_AXI_ACLK) disable iff (!S_AXI_ARESETN)
		load_valid && !load_ready |=> load_valid);

endmodule

// File: design/ball_engine.sv
`timescale 1ns/1ps

module ball_engine #(
	parameter int TICK_CYCLES = 333333
) (
	input logic S_AXI_ACLK,
	input logic S_AXI_ARESETN,
	input logic run,
	input physics_pkg::ball_t start_state,
	input logic load_valid,
	output logic load_ready,
	input physics_pkg::paddle_t paddle1,
	input physics_pkg::paddle_t paddle2,
	output physics_pkg::ball_t ball,
	output physics_pkg::status_t status
);
	import physics_pkg::*;

	localparam int TICK_W = $clog2(TICK_CYCLES + 1);
	localparam logic [TICK_W-1:0] TICK_LAST = TICK_W'(TICK_CYCLES - 1);

	typedef enum logic [2:0] {
		WAIT,
		PREDICT,
		CLASSIFY,
		BOUNCE,
		COMMIT
	} state_t;

	state_t state;
	logic [TICK_W-1:0] tick_cnt;
	logic tick_run;
	logic load_fire;
	logic step_go;
	vec3_t next_pos;
	hit_t hit;

	assign load_ready = (state == WAIT);
	assign load_fire = load_valid && load_ready;
	assign tick_run = run && status.in_bounds;
	assign step_go = tick_run && (tick_cnt == TICK_LAST);

	collision_detect u_collide (
		.pos(next_pos),
		.paddle1_pos(paddle1.pos),
		.paddle2_pos(paddle2.pos),
		.hit(hit)
	);

	// ******************************
	// Step period
	always_ff @(posedge S_AXI_ACLK) begin
		if (!S_AXI_ARESETN || load_fire) begin
			tick_cnt <= '0;
		end else if (step_go) begin
			tick_cnt <= '0;
		end else if (tick_run) begin
			tick_cnt <= tick_cnt + 1'b1;
		end
	end

	// Predicted position, only read in CLASSIFY
	always_ff @(posedge S_AXI_ACLK) begin
		if (state == PREDICT) begin
			next_pos.x <= ball.pos.x + ball.vel.x;
			next_pos.y <= ball.pos.y + ball.vel.y;
			next_pos.z <= ball.pos.z + ball.vel.z;
		end
	end

	// ******************************
	// Step FSM
	always_ff @(posedge S_AXI_ACLK) begin
		if (!S_AXI_ARESETN) begin
			state <= WAIT;
			ball.pos <= BALL_START_POS;
			ball.vel <= BALL_START_VEL;
			status <= '{in_bounds: 1'b1, impact_side: 1'b0, last_hit: HIT_NONE,
				step_count: 16'd0};
		end else begin
			case (state)
				WAIT: begin
					if (load_fire) begin
						ball <= start_state;
						status.in_bounds <= 1'b1;
						status.last_hit <= HIT_NONE;
						status.step_count <= 16'd0;
					end else if (step_go) begin
						state <= PREDICT;
					end
				end
				PREDICT: state <= CLASSIFY;
				CLASSIFY: begin
					status.last_hit <= hit;
					// Side of the net where the ball landed
					if (hit == HIT_TABLE) begin
						status.impact_side <= (next_pos.y > TABLE_CENTER.y);
					end
					if (hit == HIT_BOUNDS) begin
						status.in_bounds <= 1'b0;
						state <= WAIT;
					end else begin
						state <= BOUNCE;
					end
				end
				BOUNCE: begin
					case (status.last_hit)
						HIT_TABLE, HIT_NET: ball.vel.z <= -ball.vel.z;
						HIT_PADDLE1, HIT_PADDLE2: ball.vel.y <= -ball.vel.y;
						default: ;
					endcase
					state <= COMMIT;
				end
				COMMIT: begin
					ball.pos.x <= ball.pos.x + ball.vel.x;
					ball.pos.y <= ball.pos.y + ball.vel.y;
					ball.pos.z <= ball.pos.z + ball.vel.z;
					ball.vel.z <= ball.vel.z + GRAVITY;
					status.step_count <= status.step_count + 16'd1;
					state <= WAIT;
				end
				default: state <= WAIT;
			endcase
		end
	end

	// Once out of bounds the engine idles until a new load
	halt_out_of_bounds: assert property (@(posedge S_AXI_ACLK) disable iff (!S_AXI_ARESETN)
		state == WAIT && !status.in_bounds |=> state == WAIT);

endmodule

// File: design/collision_detect.sv
`timescale 1ns/1ps

module collision_detect (
	input physics_pkg::vec3_t pos,
	input physics_pkg::vec3_t paddle1_pos,
	input physics_pkg::vec3_t paddle2_pos,
	output physics_pkg::hit_t hit
);
	import physics_pkg::*;

	// Strictly inside center +/- (half + radius) on one axis
	// Two guard bits keep the sums from wrapping near the range ends
	function automatic logic in_span(coord_t p, coord_t c, coord_t h);
		logic signed [25:0] pw;
		logic signed [25:0] lo;
		logic signed [25:0] hi;
		pw = p;
		lo = c;
		hi = c;
		lo = lo - h - BALL_RADIUS;
		hi = hi + h + BALL_RADIUS;
		return (pw > lo) && (pw < hi);
	endfunction

	function automatic logic in_box(vec3_t p, vec3_t c, vec3_t h);
		return in_span(p.x, c.x, h.x) &&
			in_span(p.y, c.y, h.y) &&
			in_span(p.z, c.z, h.z);
	endfunction

	function automatic logic outside(vec3_t p);
		return (p.x < BOUNDS_MIN.x) || (p.x > BOUNDS_MAX.x) ||
			(p.y < BOUNDS_MIN.y) || (p.y > BOUNDS_MAX.y) ||
			(p.z < BOUNDS_MIN.z) || (p.z > BOUNDS_MAX.z);
	endfunction

	// Priority is table, paddle 1, paddle 2, net, then the play volume
	always_comb begin
		if (in_box(pos, TABLE_CENTER, TABLE_HALF)) begin
			hit = HIT_TABLE;
		end else if (in_box(pos, paddle1_pos, PADDLE_HALF)) begin
			hit = HIT_PADDLE1;
		end else if (in_box(pos, paddle2_pos, PADDLE_HALF)) begin
			hit = HIT_PADDLE2;
		end else if (in_box(pos, NET_CENTER, NET_HALF)) begin
			hit = HIT_NET;
		end else if (outside(pos)) begin
			hit = HIT_BOUNDS;
		end else begin
			hit = HIT_NONE;
		end
	end

endmodule

// File: design/paddle_tracker.sv
`timescale 1ns/1ps

module paddle_tracker #(
	parameter physics_pkg::vec3_t START_POS = '0
) (
	input logic S_AXI_ACLK,
	input logic S_AXI_ARESETN,
	input physics_pkg::vec3_t sample,
	input logic valid,
	output physics_pkg::paddle_t paddle
);

	// Image processing cannot stall, every valid sample is taken
	always_ff @(posedge S_AXI_ACLK) begin
		if (!S_AXI_ARESETN) begin
			paddle.pos <= START_POS;
			paddle.vel <= '0;
		end else if (valid) begin
			// Velocity is the step between the last two samples
			paddle.vel.x <= sample.x - paddle.pos.x;
			paddle.vel.y <= sample.y - paddle.pos.y;
			paddle.vel.z <= sample.z - paddle.pos.z;
			paddle.pos <= sample;
		end
	end

endmodule

// File: design/physics_core.sv
`timescale 1ns/1ps

module physics_core #(
	parameter int ADDR_WIDTH = 8,
	parameter int TICK_CYCLES = 333333
) (
	input logic S_AXI_ACLK,
	input logic S_AXI_ARESETN,
	input logic [ADDR_WIDTH-1:0] S_AXI_AWADDR,
	input logic S_AXI_AWVALID,
	output logic S_AXI_AWREADY,
	input logic [31:0] S_AXI_WDATA,
	input logic S_AXI_WVALID,
	output logic S_AXI_WREADY,
	output logic [1:0] S_AXI_BRESP,
	output logic S_AXI_BVALID,
	input logic S_AXI_BREADY,
	input logic [ADDR_WIDTH-1:0] S_AXI_ARADDR,
	input logic S_AXI_ARVALID,
	output logic S_AXI_ARREADY,
	output logic [31:0] S_AXI_RDATA,
	output logic [1:0] S_AXI_RRESP,
	output logic S_AXI_RVALID,
	input logic S_AXI_RREADY,
	input physics_pkg::vec3_t paddle1_sample,
	input logic paddle1_valid,
	input physics_pkg::vec3_t paddle2_sample,
	input logic paddle2_valid
);
	import physics_pkg::*;

	logic run;
	logic load_valid;
	logic load_ready;
	ball_t start_state;
	ball_t ball;
	status_t status;
	paddle_t paddle1;
	paddle_t paddle2;

	axi_lite_regs #(
		.ADDR_WIDTH(ADDR_WIDTH)
	) u_regs (
		.S_AXI_ACLK(S_AXI_ACLK),
		.S_AXI_ARESETN(S_AXI_ARESETN),
		.S_AXI_AWADDR(S_AXI_AWADDR),
		.S_AXI_AWVALID(S_AXI_AWVALID),
		.S_AXI_AWREADY(S_AXI_AWREADY),
		.S_AXI_WDATA(S_AXI_WDATA),
		.S_AXI_WVALID(S_AXI_WVALID),
		.S_AXI_WREADY(S_AXI_WREADY),
		.S_AXI_BRESP(S_AXI_BRESP),
		.S_AXI_BVALID(S_AXI_BVALID),
		.S_AXI_BREADY(S_AXI_BREADY),
		.S_AXI_ARADDR(S_AXI_ARADDR),
		.S_AXI_ARVALID(S_AXI_ARVALID),
		.S_AXI_ARREADY(S_AXI_ARREADY),
		.S_AXI_RDATA(S_AXI_RDATA),
		.S_AXI_RRESP(S_AXI_RRESP),
		.S_AXI_RVALID(S_AXI_RVALID),
		.S_AXI_RREADY(S_AXI_RREADY),
		.run(run),
		.start_state(start_state),
		.load_valid(load_valid),
		.load_ready(load_ready),
		.paddle1(paddle1),
		.paddle2(paddle2),
		.ball(ball),
		.status(status)
	);

	// One tracker per player
	paddle_tracker #(
		.START_POS(PADDLE1_START)
	) u_paddle1 (
		.S_AXI_ACLK(S_AXI_ACLK),
		.S_AXI_ARESETN(S_AXI_ARESETN),
		.sample(paddle1_sample),
		.valid(paddle1_valid),
		.paddle(paddle1)
	);

	paddle_tracker #(
		.START_POS(PADDLE2_START)
	) u_paddle2 (
		.S_AXI_ACLK(S_AXI_ACLK),
		.S_AXI_ARESETN(S_AXI_ARESETN),
		.sample(paddle2_sample),
		.valid(paddle2_valid),
		.paddle(paddle2)
	);

	ball_engine #(
		.TICK_CYCLES(TICK_CYCLES)
	) u_engine (
		.S_AXI_ACLK(S_AXI_ACLK),
		.S_AXI_ARESETN(S_AXI_ARESETN),
		.run(run),
		.start_state(start_state),
		.load_valid(load_valid),
		.load_ready(load_ready),
		.paddle1(paddle1),
		.paddle2(paddle2),
		.ball(ball),
		.status(status)
	);

endmodule

// File: design/physics_pkg.sv
package physics_pkg;

	// Fixed point coordinates, 8 fraction bits
	localparam int SCALE = 256;

	typedef logic signed [23:0] coord_t;

	typedef struct packed {
		coord_t x;
		coord_t y;
		coord_t z;
	} vec3_t;

	typedef struct packed {
		vec3_t pos;
		vec3_t vel;
	} ball_t;

	typedef struct packed {
		vec3_t pos;
		vec3_t vel;
	} paddle_t;

	typedef enum logic [2:0] {
		HIT_NONE,
		HIT_TABLE,
		HIT_PADDLE1,
		HIT_PADDLE2,
		HIT_NET,
		HIT_BOUNDS
	} hit_t;

	typedef struct packed {
		logic in_bounds;
		logic impact_side;
		hit_t last_hit;
		logic [15:0] step_count;
	} status_t;

	// Whole millimetres to fixed point
	function automatic coord_t mm(int v);
		return coord_t'(v * SCALE);
	endfunction

	// ******************************
	// World geometry
	// Z is up, Y runs along the table, X to the right
	localparam vec3_t TABLE_CENTER = '{mm(0), mm(1370), mm(740)};
	localparam vec3_t TABLE_HALF = '{mm(762), mm(1370), mm(15)};
	localparam vec3_t NET_CENTER = '{mm(0), mm(1370), mm(785)};
	localparam vec3_t NET_HALF = '{mm(762), mm(10), mm(30)};
	localparam vec3_t PADDLE_HALF = '{mm(60), mm(10), mm(70)};
	localparam coord_t BALL_RADIUS = mm(20);

	// Play volume, leaving it ends the rally
	localparam vec3_t BOUNDS_MIN = '{mm(-1000), mm(-1000), mm(0)};
	localparam vec3_t BOUNDS_MAX = '{mm(1000), mm(4000), mm(1200)};

	// ******************************
	// Start state and motion
	localparam vec3_t BALL_START_POS = '{mm(0), mm(1370), mm(840)};
	// Velocity is in raw units per step
	localparam vec3_t BALL_START_VEL = '{coord_t'(4), coord_t'(-205), coord_t'(0)};
	localparam vec3_t PADDLE1_START = '{mm(0), mm(0), mm(790)};
	localparam vec3_t PADDLE2_START = '{mm(0), mm(2740), mm(790)};
	localparam coord_t GRAVITY = coord_t'(-1);

	// ******************************
	// Register map, byte addresses
	localparam logic [7:0] REG_RUN = 8'h00;
	localparam logic [7:0] REG_LOAD = 8'h04;
	localparam logic [7:0] REG_START_POS = 8'h08;
	localparam logic [7:0] REG_START_VEL = 8'h14;
	localparam logic [7:0] REG_P1_POS = 8'h20;
	localparam logic [7:0] REG_P2_POS = 8'h2C;
	localparam logic [7:0] REG_P1_VEL = 8'h38;
	localparam logic [7:0] REG_P2_VEL = 8'h44;
	localparam logic [7:0] REG_BALL_POS = 8'h50;
	localparam logic [7:0] REG_BALL_VEL = 8'h5C;
	localparam logic [7:0] REG_IMPACT = 8'h68;
	localparam logic [7:0] REG_IN_BOUNDS = 8'h6C;
	localparam logic [7:0] REG_LAST_HIT = 8'h70;
	localparam logic [7:0] REG_STEPS = 8'h74;

endpackage

// File: list.f
+incdir+include
design/physics_pkg.sv
design/axi_lite_regs.sv
design/paddle_tracker.sv
design/collision_detect.sv
design/ball_engine.sv
design/physics_core.sv
testbench/tb_physics_core.sv

// File: include/tb_axi_tasks.svh
`ifndef TB_AXI_TASKS_SVH
`define TB_AXI_TASKS_SVH

// AXI-Lite master tasks, inputs change on the falling edge only
// BREADY and RREADY stay high, so responses last one cycle

task automatic axi_write(input logic [7:0] addr, input logic [31:0] data);
	logic seen;
	@(negedge aclk);
	awaddr = addr;
	wdata = data;
	awvalid = 1'b1;
	wvalid = 1'b1;
	seen = 1'b0;
	// BVALID rises on the handshake edge
	do begin
		@(negedge aclk);
		if (!bvalid) begin
			seen = awready && wready;
		end
	end while (!bvalid);
	awvalid = 1'b0;
	wvalid = 1'b0;
	assert (seen) else report_problem("AWREADY and WREADY did not pulse before BVALID");
	assert (bresp === 2'b00) else report_mismatch("bresp", 32'd0, {30'b0, bresp});
endtask

task automatic axi_read(input logic [7:0] addr, output logic [31:0] data);
	logic seen;
	@(negedge aclk);
	araddr = addr;
	arvalid = 1'b1;
	seen = 1'b0;
	do begin
		@(negedge aclk);
		if (!rvalid) begin
			seen = arready;
		end
	end while (!rvalid);
	data = rdata;
	arvalid = 1'b0;
	assert (seen) else report_problem("ARREADY did not pulse before RVALID");
	assert (rresp === 2'b00) else report_mismatch("rresp", 32'd0, {30'b0, rresp});
endtask

// Read one register and compare it with an expected word
task automatic read_expect(input string name, input logic [7:0] addr,
	input logic [31:0] exp);
	logic [31:0] got;
	axi_read(addr, got);
	assert (got === exp) else report_mismatch(name, exp, got);
endtask

`endif

// File: testbench/tb_physics_core.sv
`timescale 1ns/1ps

module tb_physics_core;
	import physics_pkg::*;

	localparam int TICK = 64;
	// Steps over the whole run, the free running reset phase included
	localparam int MAX_STEPS = 20;
	localparam int CYCLE_LIMIT = MAX_STEPS * TICK + 2000;

	logic aclk;
	logic aresetn;
	logic [7:0] awaddr;
	logic awvalid;
	logic awready;
	logic [31:0] wdata;
	logic wvalid;
	logic wready;
	logic [1:0] bresp;
	logic bvalid;
	logic bready;
	logic [7:0] araddr;
	logic arvalid;
	logic arready;
	logic [31:0] rdata;
	logic [1:0] rresp;
	logic rvalid;
	logic rready;
	vec3_t p1_sample;
	logic p1_valid;
	vec3_t p2_sample;
	logic p2_valid;

	int cycles;
	int errors;
	ball_t model_start;
	logic side_at_load;
	logic cur_side;
	vec3_t p1_pos;
	vec3_t p2_pos;

	physics_core #(
		.ADDR_WIDTH(8),
		.TICK_CYCLES(TICK)
	) dut0 (
		.S_AXI_ACLK(aclk),
		.S_AXI_ARESETN(aresetn),
		.S_AXI_AWADDR(awaddr),
		.S_AXI_AWVALID(awvalid),
		.S_AXI_AWREADY(awready),
		.S_AXI_WDATA(wdata),
		.S_AXI_WVALID(wvalid),
		.S_AXI_WREADY(wready),
		.S_AXI_BRESP(bresp),
		.S_AXI_BVALID(bvalid),
		.S_AXI_BREADY(bready),
		.S_AXI_ARADDR(araddr),
		.S_AXI_ARVALID(arvalid),
		.S_AXI_ARREADY(arready),
		.S_AXI_RDATA(rdata),
		.S_AXI_RRESP(rresp),
		.S_AXI_RVALID(rvalid),
		.S_AXI_RREADY(rready),
		.paddle1_sample(p1_sample),
		.paddle1_valid(p1_valid),
		.paddle2_sample(p2_sample),
		.paddle2_valid(p2_valid)
	);

	always #20 aclk = ~aclk;

	task automatic report_mismatch(input string name, input logic [31:0] exp,
		input logic [31:0] got);
		errors++;
		$display("[FAIL] t=%0t %s expected %h got %h", $time, name, exp, got);
		$display("Verification failed");
		$fatal(1);
	endtask

	task automatic report_problem(input string what);
		errors++;
		$display("%s at t=%0t", what, $time);
		$display("Verification failed");
		$fatal(1);
	endtask

	`include "tb_axi_tasks.svh"

	// Run ends here if the tests stall
	always @(posedge aclk) begin
		cycles <= cycles + 1;
		if (cycles >= CYCLE_LIMIT) begin
			$display("Run hit the cycle limit of %0d before the tests finished", CYCLE_LIMIT);
			$display("Verification failed");
			$fatal(1);
		end
	end

	function automatic logic [31:0] zext(coord_t c);
		return {8'h00, c};
	endfunction

	function automatic logic [31:0] sext(coord_t c);
		return {{8{c[23]}}, c};
	endfunction

	// ******************************
	// Reference step model
	function automatic bit near(coord_t p, coord_t c, coord_t hf);
		int lim;
		lim = int'(hf) + int'(BALL_RADIUS);
		return (int'(p) > int'(c) - lim) && (int'(p) < int'(c) + lim);
	endfunction

	function automatic bit in_box(vec3_t p, vec3_t c, vec3_t hf);
		return near(p.x, c.x, hf.x) && near(p.y, c.y, hf.y) && near(p.z, c.z, hf.z);
	endfunction

	function automatic bit out_of_play(vec3_t p);
		return int'(p.x) < int'(BOUNDS_MIN.x) || int'(p.x) > int'(BOUNDS_MAX.x) ||
			int'(p.y) < int'(BOUNDS_MIN.y) || int'(p.y) > int'(BOUNDS_MAX.y) ||
			int'(p.z) < int'(BOUNDS_MIN.z) || int'(p.z) > int'(BOUNDS_MAX.z);
	endfunction

	function automatic ball_t step_model(input ball_t b, input vec3_t p1, input vec3_t p2,
		inout logic side, output hit_t h);
		vec3_t np;
		ball_t r;
		r = b;
		np.x = b.pos.x + b.vel.x;
		np.y = b.pos.y + b.vel.y;
		np.z = b.pos.z + b.vel.z;
		if (in_box(np, TABLE_CENTER, TABLE_HALF)) h = HIT_TABLE;
		else if (in_box(np, p1, PADDLE_HALF)) h = HIT_PADDLE1;
		else if (in_box(np, p2, PADDLE_HALF)) h = HIT_PADDLE2;
		else if (in_box(np, NET_CENTER, NET_HALF)) h = HIT_NET;
		else if (out_of_play(np)) h = HIT_BOUNDS;
		else h = HIT_NONE;
		// Leaving the play volume freezes the ball
		if (h == HIT_BOUNDS) return b;
		if (h == HIT_TABLE) side = (np.y > TABLE_CENTER.y);
		if (h == HIT_TABLE || h == HIT_NET) r.vel.z = -r.vel.z;
		if (h == HIT_PADDLE1 || h == HIT_PADDLE2) r.vel.y = -r.vel.y;
		r.pos.x = b.pos.x + r.vel.x;
		r.pos.y = b.pos.y + r.vel.y;
		r.pos.z = b.pos.z + r.vel.z;
		r.vel.z = r.vel.z + GRAVITY;
		return r;
	endfunction

	// ******************************
	// Compare a consistent snapshot of the DUT with the model
	task automatic check_state();
		logic [31:0] n0;
		logic [31:0] n1;
		logic [31:0] w [0:8];
		ball_t b;
		hit_t h;
		logic side;
		logic inb;
		do begin
			axi_read(REG_STEPS, n0);
			for (int i = 0; i < 6; i++) axi_read(REG_BALL_POS + 8'(4 * i), w[i]);
			axi_read(REG_IMPACT, w[6]);
			axi_read(REG_IN_BOUNDS, w[7]);
			axi_read(REG_LAST_HIT, w[8]);
			axi_read(REG_STEPS, n1);
		end while (n0 != n1);
		b = model_start;
		side = side_at_load;
		h = HIT_NONE;
		for (int i = 0; i < int'(n0); i++) begin
			b = step_model(b, p1_pos, p2_pos, side, h);
			assert (h != HIT_BOUNDS) else report_problem("Model left the play volume early");
		end
		inb = 1'b1;
		if (w[7][0] == 1'b0) begin
			b = step_model(b, p1_pos, p2_pos, side, h);
			assert (h == HIT_BOUNDS) else report_problem("DUT left bounds, model did not");
			inb = 1'b0;
		end
		assert (w[0] === zext(b.pos.x)) else report_mismatch("ball.pos.x", zext(b.pos.x), w[0]);
		assert (w[1] === zext(b.pos.y)) else report_mismatch("ball.pos.y", zext(b.pos.y), w[1]);
		assert (w[2] === zext(b.pos.z)) else report_mismatch("ball.pos.z", zext(b.pos.z), w[2]);
		assert (w[3] === zext(b.vel.x)) else report_mismatch("ball.vel.x", zext(b.vel.x), w[3]);
		assert (w[4] === zext(b.vel.y)) else report_mismatch("ball.vel.y", zext(b.vel.y), w[4]);
		assert (w[5] === zext(b.vel.z)) else report_mismatch("ball.vel.z", zext(b.vel.z), w[5]);
		assert (w[6] === {31'b0, side}) else report_mismatch("impact_side", {31'b0, side}, w[6]);
		assert (w[7] === {31'b0, inb}) else report_mismatch("in_bounds", {31'b0, inb}, w[7]);
		assert (w[8] === {29'b0, h}) else report_mismatch("last_hit", {29'b0, h}, w[8]);
		cur_side = side;
	endtask

	task automatic load_ball(input ball_t b);
		logic [31:0] w;
		axi_write(REG_START_POS, sext(b.pos.x));
		axi_write(REG_START_POS + 8'h04, sext(b.pos.y));
		axi_write(REG_START_POS + 8'h08, sext(b.pos.z));
		axi_write(REG_START_VEL, sext(b.vel.x));
		axi_write(REG_START_VEL + 8'h04, sext(b.vel.y));
		axi_write(REG_START_VEL + 8'h08, sext(b.vel.z));
		axi_write(REG_LOAD, 32'd1);
		// Request stays pending until the engine takes it
		do axi_read(REG_LOAD, w); while (w[0]);
		model_start = b;
		side_at_load = cur_side;
	endtask

	task automatic run_steps(input int n);
		logic [31:0] w;
		axi_write(REG_RUN, 32'd1);
		do axi_read(REG_STEPS, w); while (int'(w) < n);
		axi_write(REG_RUN, 32'd0);
	endtask

	function automatic ball_t make_ball(int px, int py, int pz, int vx, int vy, int vz);
		ball_t b;
		b.pos = '{coord_t'(px), coord_t'(py), coord_t'(pz)};
		b.vel = '{coord_t'(vx), coord_t'(vy), coord_t'(vz)};
		return b;
	endfunction

	initial begin
		ball_t b;
		logic [31:0] n0;
		aclk = 1'b0;
		aresetn = 1'b0;
		{awaddr, awvalid, wdata, wvalid, araddr, arvalid} = '0;
		bready = 1'b1;
		rready = 1'b1;
		p1_sample = '0;
		p1_valid = 1'b0;
		p2_sample = '0;
		p2_valid = 1'b0;
		cycles = 0;
		errors = 0;
		cur_side = 1'b0;
		p1_pos = PADDLE1_START;
		p2_pos = PADDLE2_START;
		void'($urandom(32'h30e84c37));
		repeat (10) @(negedge aclk);
		assert (!awready && !wready && !bvalid && !arready && !rvalid)
			else report_problem("A ready or valid output is not low in reset");
		aresetn = 1'b1;

		// Reset values, the ball already runs from its start state
		read_expect("run", REG_RUN, 32'd1);
		read_expect("load_valid", REG_LOAD, 32'd0);
		read_expect("in_bounds", REG_IN_BOUNDS, 32'd1);
		for (int i = 0; i < 3; i++) begin
			read_expect("paddle1.pos", REG_P1_POS + 8'(4 * i),
				zext(PADDLE1_START[71 - 24 * i -: 24]));
			read_expect("paddle2.pos", REG_P2_POS + 8'(4 * i),
				zext(PADDLE2_START[71 - 24 * i -: 24]));
		end
		for (int i = 0; i < 6; i++) read_expect("start_state", REG_START_POS + 8'(4 * i), 32'd0);
		read_expect("unmapped", 8'h78, 32'd0);
		axi_write(REG_RUN, 32'd0);
		model_start = '{BALL_START_POS, BALL_START_VEL};
		side_at_load = 1'b0;
		check_state();

		// Random start state far from all objects, read back and load
		b = make_ball(int'($urandom % 51200) - 25600, mm(400) + int'($urandom % 51200),
			mm(1000) + int'($urandom % 25600), int'($urandom % 256) - 128,
			int'($urandom % 256) - 128, int'($urandom % 256) - 128);
		load_ball(b);
		read_expect("run", REG_RUN, 32'd0);
		read_expect("start.pos.x", REG_START_POS, zext(b.pos.x));
		read_expect("start.pos.y", REG_START_POS + 8'h04, zext(b.pos.y));
		read_expect("start.pos.z", REG_START_POS + 8'h08, zext(b.pos.z));
		read_expect("start.vel.x", REG_START_VEL, zext(b.vel.x));
		read_expect("start.vel.y", REG_START_VEL + 8'h04, zext(b.vel.y));
		read_expect("start.vel.z", REG_START_VEL + 8'h08, zext(b.vel.z));
		read_expect("step_count", REG_STEPS, 32'd0);
		check_state();

		// Free flight with gravity
		run_steps(4);
		check_state();

		// Table bounce on the far side of the net
		load_ball(make_ball(0, mm(1800), mm(780), 0, 0, mm(-10)));
		run_steps(3);
		check_state();

		// Net hit
		load_ball(make_ball(0, mm(1320), mm(810), 0, mm(20), 0));
		run_steps(2);
		check_state();

		// Paddle 2 return
		load_ball(make_ball(0, mm(2650), mm(850), 0, mm(70), 0));
		run_steps(2);
		check_state();

		// Bounds exit halts the engine
		load_ball(make_ball(0, mm(3900), mm(1000), 0, mm(200), 0));
		axi_write(REG_RUN, 32'd1);
		do axi_read(REG_IN_BOUNDS, n0); while (n0[0]);
		check_state();
		repeat (3 * TICK) @(negedge aclk);
		// The out of bounds step never commits, so the count stays at zero
		read_expect("step_count", REG_STEPS, 32'd0);
		check_state();
		axi_write(REG_RUN, 32'd0);

		// Paddle 1 tracking over two samples
		@(negedge aclk);
		p1_sample = '{coord_t'(mm(10)), coord_t'(mm(-5)), coord_t'(mm(800))};
		p1_valid = 1'b1;
		@(negedge aclk);
		p1_pos = p1_sample;
		p1_sample = '{coord_t'(mm(13)), coord_t'(mm(-9)), coord_t'(mm(790))};
		@(negedge aclk);
		p1_valid = 1'b0;
		read_expect("paddle1.pos.x", REG_P1_POS, zext(p1_sample.x));
		read_expect("paddle1.pos.y", REG_P1_POS + 8'h04, zext(p1_sample.y));
		read_expect("paddle1.pos.z", REG_P1_POS + 8'h08, zext(p1_sample.z));
		read_expect("paddle1.vel.x", REG_P1_VEL, zext(p1_sample.x - p1_pos.x));
		read_expect("paddle1.vel.y", REG_P1_VEL + 8'h04, zext(p1_sample.y - p1_pos.y));
		read_expect("paddle1.vel.z", REG_P1_VEL + 8'h08, zext(p1_sample.z - p1_pos.z));
		p1_pos = p1_sample;

		if (errors == 0) begin
			$display("Verification passed");
		end else begin
			$display("Verification failed");
		end
		$finish;
	end

endmodule
